//--- source/vmem_consts.svh
//####################################################################
// Sizing macros for the vector memory unit
// Element width must stay 32, line width must be a multiple of 32
// Derived widths are not computed, keep them in step by hand
//####################################################################

`ifndef VMEM_CONSTS_SVH
`define VMEM_CONSTS_SVH

// Vector shape
`define VMEM_NUM_LANES      4    // Lanes per vector
`define VMEM_LANE_BITS      2    // log2 of lane count
`define VMEM_WORD_WIDTH     32   // Element and control width

// Data memory line
`define VMEM_LINE_WIDTH     128  // One memory access moves a full line
`define VMEM_LINE_BYTES     16   // Byte enables per line
`define VMEM_WORD_SEL_BITS  2    // Address bits [3:2] pick the word

`endif

//--- source/vmem_pkg.sv
//####################################################################
// Shared types for the vector memory unit
// mem_op_t bit order is {pattern, size, signd, we}, op[5:0]
//####################################################################
`default_nettype none

`include "vmem_consts.svh"

package vmem_pkg;

  typedef enum logic [1:0] {
    PAT_UNIT    = 2'd0,  // Consecutive elements
    PAT_STRIDED = 2'd1,  // Base plus lane times stride
    PAT_INDEXED = 2'd2   // Base plus per-lane index
  } mem_pattern_e;

  // Code 3 falls through to word everywhere
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } mem_size_e;

  typedef struct packed {
    mem_pattern_e pattern;  // op[5:4]
    mem_size_e    size;     // op[3:2]
    logic         signd;    // op[1], sign extend loads
    logic         we;       // op[0], 1 is store
  } mem_op_t;

  typedef logic [`VMEM_LANE_BITS-1:0]  lane_idx_t;
  typedef logic [`VMEM_WORD_WIDTH-1:0] word_t;
  typedef word_t                       lane_words_t [`VMEM_NUM_LANES];
  typedef logic [`VMEM_NUM_LANES-1:0]  lane_mask_t;
  typedef logic [`VMEM_LINE_WIDTH-1:0] line_t;
  typedef logic [`VMEM_LINE_BYTES-1:0] line_byteen_t;

endpackage

`default_nettype wire

//--- source/vmem_addr_gen.sv
//####################################################################
// Per-lane byte address generator, purely combinational
// Stride and index are not range checked, results wrap at 32 bits
// Elements must land naturally aligned, nothing here enforces it
//####################################################################
`default_nettype none

`include "vmem_consts.svh"

module vmem_addr_gen
  import vmem_pkg::*;
(
  input  mem_op_t     op,
  input  word_t       cbase,
  input  word_t       cstride,
  input  lane_words_t vindex,
  output lane_words_t lane_addr
);

  logic [1:0] elem_shift;                   // log2 of element bytes
  word_t      lane_off [`VMEM_NUM_LANES];   // Offset from base per lane

  // Size code 3 acts as a word
  always_comb
  begin
    case (op.size)
      SZ_BYTE: elem_shift = 2'd0;
      SZ_HALF: elem_shift = 2'd1;
      default: elem_shift = 2'd2;
    endcase
  end

  // Lane multiply replaces a precomputed stride table
  always_comb
  begin
    for (int k = 0; k < `VMEM_NUM_LANES; k++)
    begin
      case (op.pattern)
        PAT_STRIDED: lane_off[k] = (word_t'(k) * cstride) << elem_shift;
        PAT_INDEXED: lane_off[k] = vindex[k];  // Index is already in bytes
        default:     lane_off[k] = word_t'(k) << elem_shift;
      endcase
      lane_addr[k] = cbase + lane_off[k];
    end
  end

endmodule

`default_nettype wire

//--- source/velm_queue.sv
//####################################################################
// Per-lane element queue, lane 0 is the head
// Load takes a whole vector, shift drops the head and pulls zeros in
// Load and shift must never be asserted in the same cycle
//####################################################################
`default_nettype none

`include "vmem_consts.svh"

module velm_queue #(
  parameter type elem_t = logic  // Payload per lane
) (
  input  logic  clk,
  input  logic  resetn,
  input  logic  load,                          // Capture in_elems
  input  logic  shift,                         // Advance one lane
  input  elem_t in_elems [`VMEM_NUM_LANES],
  output elem_t head
);

  elem_t q [`VMEM_NUM_LANES];  // Lane storage

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      // Mask copy must come up empty
      for (int i = 0; i < `VMEM_NUM_LANES; i++)
        q[i] <= '0;
    end
    else if (load)
      q <= in_elems;
    else if (shift)
    begin
      for (int i = 0; i < `VMEM_NUM_LANES - 1; i++)
        q[i] <= q[i + 1];                      // Move toward lane 0
      q[`VMEM_NUM_LANES - 1] <= '0;            // Top lane empties
    end
  end

  assign head = q[0];

  // Controller loads only while idle and shifts only while issuing
  a_load_shift_excl: assert property (@(posedge clk) disable iff (!resetn)
    !(load && shift))
    else $error("velm_queue: load and shift together");

endmodule

`default_nettype wire

//--- source/vmem_ctrl.sv
//####################################################################
// Issue FSM, one lane per cycle starting at lane 0
// Memory port is a plain en/wait pair, request held while wait is high
// One drain cycle covers the read data of the last lane
//####################################################################
`default_nettype none

`include "vmem_consts.svh"

module vmem_ctrl
  import vmem_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  logic      enable,     // Operation requested
  input  logic      head_mask,  // Mask bit of the head lane
  input  logic      dmem_wait,  // Memory back-pressure
  output logic      load,       // Fill the queues
  output logic      shift,      // Head lane done
  output logic      dmem_en,
  output logic      stall,
  output lane_idx_t lane        // Lane now at the head
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DRAIN
  } state_e;

  state_e state;
  logic   last_lane;

  assign last_lane = (lane == lane_idx_t'(`VMEM_NUM_LANES - 1));

  // Take a new op only while idle
  assign load    = (state == ST_IDLE) && enable;
  assign dmem_en = (state == ST_ISSUE) && head_mask;
  // Masked lane passes at once, active lane waits for acceptance
  assign shift   = (state == ST_ISSUE) && (!head_mask || !dmem_wait);
  assign stall   = (state == ST_ISSUE) || (state == ST_DRAIN);

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      state <= ST_IDLE;
      lane  <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          lane <= '0;
          if (load)
            state <= ST_ISSUE;
        end
        ST_ISSUE:
        begin
          if (shift)
          begin
            lane <= lane + 1'b1;                  // Wraps back to 0 after last
            if (last_lane)
              state <= ST_DRAIN;
          end
        end
        ST_DRAIN: state <= ST_IDLE;               // Last load data returns here
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // Requests only come out of the issue state
  a_en_in_issue: assert property (@(posedge clk) disable iff (!resetn)
    dmem_en |-> (state == ST_ISSUE))
    else $error("vmem_ctrl: dmem_en outside ISSUE");

  // A stalled request stays on the same lane
  a_hold_on_wait: assert property (@(posedge clk) disable iff (!resetn)
    (dmem_en && dmem_wait) |=> (dmem_en && $stable(lane)))
    else $error("vmem_ctrl: request dropped under wait");

endmodule

`default_nettype wire

//--- source/vstore_align.sv
//####################################################################
// Store aligner, places one element into a memory line
// Big-endian inside each word, byte offset 0 is bits 31:24
// Assumes natural alignment, size code 3 stores a word
//####################################################################
`default_nettype none

module vstore_align
  import vmem_pkg::*;
(
  input  word_t        addr,       // Element byte address
  input  word_t        data,       // Element in low bits
  input  mem_size_e    size,
  output line_t        writedata,
  output line_byteen_t byteen
);

  logic [3:0] word_be;    // Enables inside the word, bit 3 is offset 0
  word_t      word_data;  // Data placed inside the word

  always_comb
  begin
    case (size)
      SZ_BYTE:
      begin
        word_be   = 4'b1000 >> addr[1:0];
        word_data = {data[7:0], 24'b0} >> {addr[1:0], 3'b000};
      end
      SZ_HALF:
      begin
        // Only addr[1] matters for an aligned halfword
        word_be   = addr[1] ? 4'b0011 : 4'b1100;
        word_data = addr[1] ? {16'b0, data[15:0]} : {data[15:0], 16'b0};
      end
      default:
      begin
        word_be   = 4'b1111;
        word_data = data;
      end
    endcase
  end

  // Word w sits at bits 32w+31:32w of the line
  assign writedata = line_t'(word_data) << {addr[3:2], 5'b00000};
  assign byteen    = line_byteen_t'(word_be) << {addr[3:2], 2'b00};

endmodule

`default_nettype wire

//--- source/vload_align.sv
//####################################################################
// Load aligner, one cycle from accepted request to voutput_we
// Expects the addressed line on readdata the cycle after acceptance
// voutput is zero in every lane that is not being written
//####################################################################
`default_nettype none

`include "vmem_consts.svh"

module vload_align
  import vmem_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        issue,      // Load request accepted
  input  lane_idx_t   lane,
  input  word_t       addr,
  input  mem_size_e   size,
  input  logic        signd,
  input  line_t       readdata,
  output lane_words_t voutput,
  output lane_mask_t  voutput_we
);

  logic                           valid_q;  // Line arrives this cycle
  lane_idx_t                      lane_q;
  logic [`VMEM_WORD_SEL_BITS+1:0] off_q;    // Word select and byte offset
  mem_size_e                      size_q;
  logic                           signd_q;

  word_t       word_sel;
  logic [15:0] half_sel;
  logic [7:0]  byte_sel;
  word_t       result;

  always_ff @(posedge clk)
  begin
    if (!resetn)
      valid_q <= 1'b0;
    else
      valid_q <= issue;
  end

  // Request details, only looked at under valid_q
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      lane_q  <= lane;
      off_q   <= addr[`VMEM_WORD_SEL_BITS+1:0];
      size_q  <= size;
      signd_q <= signd;
    end
  end

  always_comb
  begin
    word_sel = readdata[{off_q[3:2], 5'b00000} +: 32];
    half_sel = word_sel[{~off_q[1], 4'b0000} +: 16];     // Offset 0 is upper half
    byte_sel = word_sel[{~off_q[1:0], 3'b000} +: 8];     // Offset 0 is top byte
    case (size_q)
      SZ_BYTE: result = {{24{signd_q & byte_sel[7]}}, byte_sel};
      SZ_HALF: result = {{16{signd_q & half_sel[15]}}, half_sel};
      default: result = word_sel;
    endcase
  end

  // Steer into the one lane that asked
  always_comb
  begin
    for (int i = 0; i < `VMEM_NUM_LANES; i++)
    begin
      voutput_we[i] = valid_q && (lane_q == lane_idx_t'(i));
      voutput[i]    = voutput_we[i] ? result : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/vmem_unit.sv
//####################################################################
// Vector memory unit top, serial issue of unit, strided, indexed ops
// Inputs are sampled only in the cycle the op is taken
// Addresses go out line aligned, byte enables pick the element
//####################################################################
`default_nettype none

`include "vmem_consts.svh"

module vmem_unit
  import vmem_pkg::*;
(
  input  logic         clk,
  input  logic         resetn,
  input  logic         enable,
  input  mem_op_t      op,
  input  word_t        cbase,
  input  word_t        cstride,
  input  lane_mask_t   vmask,
  input  lane_words_t  vindex,
  input  lane_words_t  vwritedata,
  output logic         stall,
  output lane_words_t  voutput,
  output lane_mask_t   voutput_we,
  output logic         dmem_en,
  output logic         dmem_we,
  output word_t        dmem_address,
  output line_byteen_t dmem_byteen,
  output line_t        dmem_writedata,
  input  line_t        dmem_readdata,
  input  logic         dmem_wait
);

  lane_words_t lane_addr;
  logic        mask_in [`VMEM_NUM_LANES];  // vmask as an unpacked vector
  mem_op_t     op_q;                       // Op in flight
  logic        q_load;
  logic        q_shift;
  word_t       head_addr;
  word_t       head_data;
  logic        head_mask;
  lane_idx_t   lane;
  logic        ld_issue;                   // Accepted load request

  always_comb
  begin
    for (int i = 0; i < `VMEM_NUM_LANES; i++)
      mask_in[i] = vmask[i];
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
      op_q <= '0;
    else if (q_load)
      op_q <= op;
  end

  vmem_addr_gen u_addr_gen (
    .op        (op),
    .cbase     (cbase),
    .cstride   (cstride),
    .vindex    (vindex),
    .lane_addr (lane_addr)
  );

  velm_queue #(.elem_t(word_t)) u_addr_q (
    .clk(clk), .resetn(resetn), .load(q_load), .shift(q_shift),
    .in_elems(lane_addr), .head(head_addr)
  );

  // Store data rides along even for loads, it is simply unused
  velm_queue #(.elem_t(word_t)) u_data_q (
    .clk(clk), .resetn(resetn), .load(q_load), .shift(q_shift),
    .in_elems(vwritedata), .head(head_data)
  );

  velm_queue #(.elem_t(logic)) u_mask_q (
    .clk(clk), .resetn(resetn), .load(q_load), .shift(q_shift),
    .in_elems(mask_in), .head(head_mask)
  );

  vmem_ctrl u_ctrl (
    .clk       (clk),
    .resetn    (resetn),
    .enable    (enable),
    .head_mask (head_mask),
    .dmem_wait (dmem_wait),
    .load      (q_load),
    .shift     (q_shift),
    .dmem_en   (dmem_en),
    .stall     (stall),
    .lane      (lane)
  );

  vstore_align u_st_align (
    .addr      (head_addr),
    .data      (head_data),
    .size      (op_q.size),
    .writedata (dmem_writedata),
    .byteen    (dmem_byteen)
  );

  assign ld_issue = dmem_en && !dmem_wait && !op_q.we;

  vload_align u_ld_align (
    .clk        (clk),
    .resetn     (resetn),
    .issue      (ld_issue),
    .lane       (lane),
    .addr       (head_addr),
    .size       (op_q.size),
    .signd      (op_q.signd),
    .readdata   (dmem_readdata),
    .voutput    (voutput),
    .voutput_we (voutput_we)
  );

  assign dmem_we      = op_q.we;
  assign dmem_address = {head_addr[`VMEM_WORD_WIDTH-1:`VMEM_WORD_SEL_BITS+2],
                         {(`VMEM_WORD_SEL_BITS + 2){1'b0}}};  // Line aligned

  // Results only ever come back for loads, one lane at a time
  a_we_load_only: assert property (@(posedge clk) disable iff (!resetn)
    (voutput_we != '0) |-> (!op_q.we && $onehot(voutput_we)))
    else $error("vmem_unit: bad voutput_we");

endmodule

`default_nettype wire

//--- sim/dmem_model.sv
//####################################################################
// Registered data memory model, 256 bytes, filled with addr ^ 8'h3c
// Big-endian inside each word, only address bits [7:4] pick the line
// Each request sees 0 to 2 wait cycles drawn from $urandom
//####################################################################
`default_nettype none

module dmem_model
  import vmem_pkg::*;
#(
  parameter logic [31:0] SEED = 32'hb085_c1ac  // Wait pattern seed
) (
  input  logic         clk,
  input  logic         dmem_en,
  input  logic         dmem_we,
  input  word_t        dmem_address,
  input  line_byteen_t dmem_byteen,
  input  line_t        dmem_writedata,
  output line_t        dmem_readdata,
  output logic         dmem_wait
);

  logic [7:0] mem [256];  // Byte storage
  logic [1:0] wait_left;  // Wait cycles still owed to the pending request

  assign dmem_wait = dmem_en && (wait_left != 2'd0);

  // Line byte p sits at bits 8p+7:8p and maps to line offset p ^ 3
  initial
  begin
    logic [7:0] base;
    line_t      line_v;
    for (int a = 0; a < 256; a++)
      mem[a] = 8'(a) ^ 8'h3c;
    void'($urandom(SEED));                 // Seeded once for the run
    wait_left     <= 2'($urandom % 3);     // Drawn ahead for the first request
    dmem_readdata <= '0;
    forever
    begin
      @(posedge clk);
      if (dmem_en && (wait_left != 2'd0))
        wait_left <= wait_left - 2'd1;     // Request held, count down
      else if (dmem_en)
      begin
        base = {dmem_address[7:4], 4'h0};
        for (int p = 0; p < 16; p++)
        begin
          if (dmem_we && dmem_byteen[p])
            mem[base + 8'(p ^ 3)] = dmem_writedata[8*p +: 8];
          line_v[8*p +: 8] = mem[base + 8'(p ^ 3)];
        end
        if (!dmem_we)
          dmem_readdata <= line_v;         // Line shows up next cycle
        wait_left <= 2'($urandom % 3);     // Next request's wait
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_vmem_unit.sv
//####################################################################
// Table driven testbench for vmem_unit with a registered memory model
// Expected images assume the memory fill addr ^ 8'h3c
// Rows run in order so later load rows read back earlier stores
//####################################################################
`default_nettype none

`include "vmem_consts.svh"

module tb_vmem_unit
  import vmem_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 5;
  localparam int NUM_ROWS      = 7;
  localparam int NL            = `VMEM_NUM_LANES;
  localparam int WATCHDOG_TIME = (RESET_CYCLES + 4 + NUM_ROWS * 20) * CLK_PERIOD;

  logic         clk = 1'b0;
  logic         resetn;
  logic         enable;
  mem_op_t      op;
  word_t        cbase;
  word_t        cstride;
  lane_mask_t   vmask;
  lane_words_t  vindex;
  lane_words_t  vwritedata;
  logic         stall;
  lane_words_t  voutput;
  lane_mask_t   voutput_we;
  logic         dmem_en;
  logic         dmem_we;
  word_t        dmem_address;
  line_byteen_t dmem_byteen;
  line_t        dmem_writedata;
  line_t        dmem_readdata;
  logic         dmem_wait;

  // Stimulus and expected lane images per row
  mem_op_t    row_op     [NUM_ROWS];
  word_t      row_base   [NUM_ROWS];
  word_t      row_stride [NUM_ROWS];
  lane_mask_t row_mask   [NUM_ROWS];
  word_t      row_index  [NUM_ROWS][NL];
  word_t      row_wdata  [NUM_ROWS][NL];
  word_t      row_expect [NUM_ROWS][NL];

  int err_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  vmem_unit u_vmem_unit (
    .clk            (clk),
    .resetn         (resetn),
    .enable         (enable),
    .op             (op),
    .cbase          (cbase),
    .cstride        (cstride),
    .vmask          (vmask),
    .vindex         (vindex),
    .vwritedata     (vwritedata),
    .stall          (stall),
    .voutput        (voutput),
    .voutput_we     (voutput_we),
    .dmem_en        (dmem_en),
    .dmem_we        (dmem_we),
    .dmem_address   (dmem_address),
    .dmem_byteen    (dmem_byteen),
    .dmem_writedata (dmem_writedata),
    .dmem_readdata  (dmem_readdata),
    .dmem_wait      (dmem_wait)
  );

  dmem_model #(.SEED(32'hb085_c1ac)) u_dmem (
    .clk            (clk),
    .dmem_en        (dmem_en),
    .dmem_we        (dmem_we),
    .dmem_address   (dmem_address),
    .dmem_byteen    (dmem_byteen),
    .dmem_writedata (dmem_writedata),
    .dmem_readdata  (dmem_readdata),
    .dmem_wait      (dmem_wait)
  );

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      err_count++;
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic fill_table();
    // Unit word load from base 0x20
    row_op[0]     = '{PAT_UNIT, SZ_WORD, 1'b0, 1'b0};
    row_base[0]   = 32'h20;
    row_stride[0] = 32'h0;
    row_mask[0]   = 4'b1111;
    row_index[0]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_wdata[0]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_expect[0] = '{32'h1c1d1e1f, 32'h18191a1b, 32'h14151617, 32'h10111213};
    // Strided signed halfword load of 0x80 to 0x92 with lane 2 masked
    row_op[1]     = '{PAT_STRIDED, SZ_HALF, 1'b1, 1'b0};
    row_base[1]   = 32'h80;
    row_stride[1] = 32'd3;
    row_mask[1]   = 4'b1011;
    row_index[1]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_wdata[1]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_expect[1] = '{32'hffffbcbd, 32'hffffbabb, 32'h0, 32'hffffaeaf};
    // Indexed unsigned byte load
    row_op[2]     = '{PAT_INDEXED, SZ_BYTE, 1'b0, 1'b0};
    row_base[2]   = 32'h0;
    row_stride[2] = 32'h0;
    row_mask[2]   = 4'b1111;
    row_index[2]  = '{32'hc5, 32'h07, 32'h31, 32'hfe};
    row_wdata[2]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_expect[2] = '{32'hf9, 32'h3b, 32'h0d, 32'hc2};
    // Unit byte store to 0x50..0x53 skipping 0x51
    row_op[3]     = '{PAT_UNIT, SZ_BYTE, 1'b0, 1'b1};
    row_base[3]   = 32'h50;
    row_stride[3] = 32'h0;
    row_mask[3]   = 4'b1101;
    row_index[3]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_wdata[3]  = '{32'h111111a1, 32'h222222b2, 32'h333333c3, 32'h444444d4};
    row_expect[3] = '{32'h0, 32'h0, 32'h0, 32'h0};
    // Strided halfword store at 0x60 0x66 0x6c 0x72
    row_op[4]     = '{PAT_STRIDED, SZ_HALF, 1'b0, 1'b1};
    row_base[4]   = 32'h60;
    row_stride[4] = 32'd3;
    row_mask[4]   = 4'b1111;
    row_index[4]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_wdata[4]  = '{32'h0000beef, 32'h1234cafe, 32'hffff5a5a, 32'h00007788};
    row_expect[4] = '{32'h0, 32'h0, 32'h0, 32'h0};
    // Indexed word load of the stored words 0x50 0x60 0x64 0x70
    row_op[5]     = '{PAT_INDEXED, SZ_WORD, 1'b0, 1'b0};
    row_base[5]   = 32'h50;
    row_stride[5] = 32'h0;
    row_mask[5]   = 4'b1111;
    row_index[5]  = '{32'h00, 32'h10, 32'h14, 32'h20};
    row_wdata[5]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_expect[5] = '{32'ha16dc3d4, 32'hbeef5e5f, 32'h5859cafe, 32'h4c4d7788};
    // Unit word load of 0x6c with upper lanes masked
    row_op[6]     = '{PAT_UNIT, SZ_WORD, 1'b0, 1'b0};
    row_base[6]   = 32'h6c;
    row_stride[6] = 32'h0;
    row_mask[6]   = 4'b0001;
    row_index[6]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_wdata[6]  = '{32'h0, 32'h0, 32'h0, 32'h0};
    row_expect[6] = '{32'h5a5a5253, 32'h0, 32'h0, 32'h0};
  endtask

  // Starts right after an edge with the unit idle
  task automatic apply_row(input int r);
    word_t      image [NL];
    lane_mask_t written;
    lane_mask_t exp_written;
    for (int k = 0; k < NL; k++)
      image[k] = '0;
    written     = '0;
    exp_written = row_op[r].we ? '0 : row_mask[r];  // Loads write back active lanes only
    enable  <= 1'b1;
    op      <= row_op[r];
    cbase   <= row_base[r];
    cstride <= row_stride[r];
    vmask   <= row_mask[r];
    for (int k = 0; k < NL; k++)
    begin
      vindex[k]     <= row_index[r][k];
      vwritedata[k] <= row_wdata[r][k];
    end
    @(posedge clk);                                // Op taken on this edge
    enable  <= 1'b0;
    op      <= mem_op_t'(~row_op[r]);              // Unit must not look again
    cbase   <= ~row_base[r];
    cstride <= ~row_stride[r];
    vmask   <= ~row_mask[r];
    for (int k = 0; k < NL; k++)
    begin
      vindex[k]     <= ~row_index[r][k];
      vwritedata[k] <= ~row_wdata[r][k];
    end
    do
    begin
      @(posedge clk);
      for (int k = 0; k < NL; k++)
      begin
        if (voutput_we[k])
        begin
          image[k]   = voutput[k];
          written[k] = 1'b1;
        end
        else
          check_value($sformatf("voutput[%0d] idle", k), voutput[k], '0);
      end
    end
    while (stall);
    for (int k = 0; k < NL; k++)
      check_value($sformatf("row %0d voutput[%0d]", r, k), image[k], row_expect[r][k]);
    check_value($sformatf("row %0d voutput_we", r), 32'(written), 32'(exp_written));
  endtask

  initial
  begin
    resetn  = 1'b0;
    enable  = 1'b0;
    op      = '0;
    cbase   = '0;
    cstride = '0;
    vmask   = '0;
    for (int k = 0; k < NL; k++)
    begin
      vindex[k]     = '0;
      vwritedata[k] = '0;
    end
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
    // Outputs stay quiet until the first op
    repeat (3)
    begin
      @(posedge clk);
      check_value("stall", 32'(stall), '0);
      check_value("dmem_en", 32'(dmem_en), '0);
      check_value("voutput_we", 32'(voutput_we), '0);
    end
    for (int r = 0; r < NUM_ROWS; r++)
      apply_row(r);
    if (err_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Watchdog allows about 20 cycles per row plus reset
  initial
  begin
    #(WATCHDOG_TIME);
    $display("Timeout: run did not finish within %0d time units", WATCHDOG_TIME);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/vmem_pkg.sv
source/vmem_addr_gen.sv
source/velm_queue.sv
source/vmem_ctrl.sv
source/vstore_align.sv
source/vload_align.sv
source/vmem_unit.sv
sim/dmem_model.sv
sim/tb_vmem_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vmem_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vmem_unit -f build.f -o sim_vmem

./obj_dir/sim_vmem > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
